//--- hw/fpu_addsub.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// combinational add/sub that truncates and never rounds
// bits shifted out during alignment are lost
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "fpu_consts.svh"

module fpu_addsub (
  input  fpu_pkg::fpu_unpacked_t a,
  input  fpu_pkg::fpu_unpacked_t b,
  input  logic                   subtract,
  output fpu_pkg::fpu_unpacked_t sum
);

  // mantissa plus guard bits with the sign of the raw sum on top
  localparam int SUM_W = `FPU_MANT_W + `FPU_GUARD_W;

  logic [SUM_W-1:0]      a_ext;
  logic [SUM_W-1:0]      b_ext;
  logic [SUM_W-1:0]      a_aligned;
  logic [SUM_W-1:0]      b_aligned;
  logic [SUM_W-1:0]      a_signed;
  logic [SUM_W-1:0]      b_signed;
  logic [SUM_W-1:0]      raw;
  logic [SUM_W-1:0]      mag;
  logic [SUM_W-1:0]      mag_norm;
  logic [`FPU_EXP_W-1:0] exp_big;
  logic                  res_sign;
  logic [4:0]            zcount;

  // leading zeros of the 24-bit mantissa field or 24 when empty
  function automatic logic [4:0] lzc(input logic [`FPU_MANT_W-1:0] v);
    logic [4:0] n;
    logic       found;
    n     = 5'(`FPU_MANT_W);
    found = 1'b0;
    for (int i = `FPU_MANT_W - 1; i >= 0; i--) begin
      if (!found && v[i]) begin
        n     = 5'(`FPU_MANT_W - 1 - i);
        found = 1'b1;
      end
    end
    return n;
  endfunction

  assign a_ext = {{`FPU_GUARD_W{1'b0}}, a.mant};
  assign b_ext = {{`FPU_GUARD_W{1'b0}}, b.mant};

  // shift the smaller one right by the exponent gap
  assign a_aligned = (a.exp < b.exp) ? a_ext >> (b.exp - a.exp) : a_ext;
  assign b_aligned = (b.exp < a.exp) ? b_ext >> (a.exp - b.exp) : b_ext;
  assign exp_big   = (a.exp < b.exp) ? b.exp : a.exp;

  // two's complement of negative operands
  assign a_signed = a.sign ? -a_aligned : a_aligned;
  assign b_signed = b.sign ? -b_aligned : b_aligned;

  assign raw      = subtract ? a_signed - b_signed : a_signed + b_signed;
  assign res_sign = raw[SUM_W-1];
  assign mag      = res_sign ? -raw : raw;

  // bit 25 of mag is never set since two mantissas sum to less than 2^25
  assign zcount = lzc(mag[`FPU_MANT_W-1:0]);

  always_comb begin
    sum      = '0;
    mag_norm = '0;
    if (mag == '0) begin
      // exact cancellation gives all zeros
      sum = '0;
    end else if (mag[`FPU_MANT_W]) begin
      // carry out of the hidden bit drops the lsb
      mag_norm = mag >> 1;
      sum.sign = res_sign;
      sum.exp  = exp_big + 1'b1;
      sum.mant = mag_norm[`FPU_MANT_W-1:0];
    end else begin
      mag_norm = mag << zcount;
      sum.sign = res_sign;
      sum.exp  = exp_big - `FPU_EXP_W'(zcount);
      sum.mant = mag_norm[`FPU_MANT_W-1:0];
    end
  end

endmodule

//--- hw/fpu_consts.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fixed IEEE-754 single precision field widths
// no special values, all operands assumed normal
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef FPU_CONSTS_SVH
`define FPU_CONSTS_SVH

// full ieee word
`define FPU_WIDTH 32

// biased exponent field
`define FPU_EXP_W 8

// stored fraction, hidden bit not included
`define FPU_FRAC_W 23

// fraction plus hidden bit
`define FPU_MANT_W 24

// extra upper bits in add/sub for the carry and the sign
`define FPU_GUARD_W 2

// exponent bias
`define FPU_BIAS 127

`endif

//--- hw/fpu_float2int.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// float to unsigned int, truncates toward zero
// sign ignored, result keeps only the low 32 bits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "fpu_consts.svh"

module fpu_float2int (
  input  fpu_pkg::fpu_unpacked_t a,
  output logic [`FPU_WIDTH-1:0]  value
);

  logic [`FPU_EXP_W-1:0] shift;
  logic [`FPU_WIDTH-1:0] mant_ext;

  // unbiased exponent, only meaningful when exp >= bias
  assign shift    = a.exp - `FPU_EXP_W'(`FPU_BIAS);
  assign mant_ext = `FPU_WIDTH'(a.mant);

  always_comb begin
    if (a.exp < `FPU_EXP_W'(`FPU_BIAS)) begin
      // magnitude below one
      value = '0;
    end else if (shift <= `FPU_EXP_W'(`FPU_FRAC_W)) begin
      // binary point still inside the fraction
      // drop the fraction bits below it
      value = mant_ext >> (`FPU_EXP_W'(`FPU_FRAC_W) - shift);
    end else begin
      // integer past the fraction, zeros fill the low bits
      // shifts of 32 or more leave zero
      value = mant_ext << (shift - `FPU_EXP_W'(`FPU_FRAC_W));
    end
  end

endmodule

//--- hw/fpu_mul.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// combinational multiply, round to nearest, ties to even
// exponent must stay in range, no overflow detection
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "fpu_consts.svh"

module fpu_mul (
  input  fpu_pkg::fpu_unpacked_t a,
  input  fpu_pkg::fpu_unpacked_t b,
  output fpu_pkg::fpu_unpacked_t product
);

  localparam int PROD_W = 2 * `FPU_MANT_W;
  // one extra bit keeps the exponent sum from wrapping before the bias
  localparam int ESUM_W = `FPU_EXP_W + 2;

  logic [PROD_W-1:0]      prod;
  logic [PROD_W-1:0]      prod_norm;
  logic [ESUM_W-1:0]      exp_sum;
  logic [`FPU_EXP_W-1:0]  exp_norm;
  logic [`FPU_MANT_W-1:0] kept;
  logic                   guard_bit;
  logic                   sticky;
  logic                   round_up;
  logic [`FPU_MANT_W:0]   rounded;
  logic                   carry;

  // 1.x times 1.x lies in [1, 4), so the product has one or two integer bits
  assign prod = a.mant * b.mant;

  assign exp_sum = {2'b00, a.exp} + {2'b00, b.exp} - ESUM_W'(`FPU_BIAS)
                   + ESUM_W'(prod[PROD_W-1]);
  assign exp_norm = exp_sum[`FPU_EXP_W-1:0];

  // leading one to the top bit
  assign prod_norm = prod[PROD_W-1] ? prod : prod << 1;

  // upper 24 bits kept, the rest decide rounding
  assign kept      = prod_norm[PROD_W-1:`FPU_MANT_W];
  assign guard_bit = prod_norm[`FPU_MANT_W-1];
  assign sticky    = |prod_norm[`FPU_MANT_W-2:0];

  // above half rounds up, exact half only when the kept lsb is odd
  assign round_up = guard_bit & (sticky | kept[0]);

  assign rounded = {1'b0, kept} + (`FPU_MANT_W + 1)'(round_up);
  assign carry   = rounded[`FPU_MANT_W];

  assign product.sign = a.sign ^ b.sign;
  // a carry out of rounding leaves exactly 10.000..., shift right once
  assign product.exp  = exp_norm + `FPU_EXP_W'(carry);
  assign product.mant = carry ? rounded[`FPU_MANT_W:1] : rounded[`FPU_MANT_W-1:0];

endmodule

//--- hw/fpu_operand_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// operand capture, one cycle after load is raised
// a zero exponent only clears the hidden bit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "fpu_consts.svh"

module fpu_operand_regs (
  input  logic                   clk,
  input  logic                   arst,
  input  logic [`FPU_WIDTH-1:0]  a_operand,
  input  logic [`FPU_WIDTH-1:0]  b_operand,
  input  logic                   load,
  output fpu_pkg::fpu_unpacked_t a,
  output fpu_pkg::fpu_unpacked_t b
);

  // field positions inside the ieee word
  localparam int EXP_LSB  = `FPU_FRAC_W;
  localparam int SIGN_BIT = `FPU_WIDTH - 1;

  always_ff @(posedge clk, posedge arst) begin
    if (arst) begin
      a <= '0;
      b <= '0;
    end else if (load) begin
      a.sign <= a_operand[SIGN_BIT];
      a.exp  <= a_operand[SIGN_BIT-1:EXP_LSB];
      // hidden bit only for a non-zero exponent
      a.mant <= {a_operand[SIGN_BIT-1:EXP_LSB] != '0, a_operand[`FPU_FRAC_W-1:0]};

      b.sign <= b_operand[SIGN_BIT];
      b.exp  <= b_operand[SIGN_BIT-1:EXP_LSB];
      b.mant <= {b_operand[SIGN_BIT-1:EXP_LSB] != '0, b_operand[`FPU_FRAC_W-1:0]};
    end
    // otherwise both operands hold until the next command
  end

endmodule

//--- hw/fpu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types of the fpu
// unpacked operands carry the hidden bit in the mantissa
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "fpu_consts.svh"

package fpu_pkg;

  // opcode as driven on the operation port
  typedef enum logic [1:0] {
    op_add          = 2'd0,
    op_sub          = 2'd1,
    op_mul          = 2'd2,
    op_float_to_int = 2'd3
  } fpu_op_e;

  // sequencer states
  // st_done is the first cycle with cmd_end high
  typedef enum logic [2:0] {
    st_idle           = 3'd0,
    st_load           = 3'd1,
    st_exec           = 3'd2,
    st_done           = 3'd3,
    st_wait_start_low = 3'd4
  } seq_state_e;

  // sign, biased exponent and 1.fraction mantissa
  // 33 bits in total
  typedef struct packed {
    logic                  sign;
    logic [`FPU_EXP_W-1:0]  exp;
    logic [`FPU_MANT_W-1:0] mant;
  } fpu_unpacked_t;

endpackage

//--- hw/fpu_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// command sequencer, one command at a time
// operands and opcode must hold until cmd_end rises
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "fpu_consts.svh"

module fpu_sequencer (
  input  logic                   clk,
  input  logic                   arst,
  input  logic                   start,
  input  fpu_pkg::fpu_op_e       operation,
  input  fpu_pkg::fpu_unpacked_t sum,
  input  fpu_pkg::fpu_unpacked_t product,
  input  logic [`FPU_WIDTH-1:0]  int_value,
  output logic                   load,
  output logic                   subtract,
  output logic [`FPU_WIDTH-1:0]  result,
  output logic                   busy,
  output logic                   cmd_end
);

  import fpu_pkg::*;

  seq_state_e state;
  seq_state_e state_next;

  always_comb begin
    state_next = state;
    case (state)
      st_idle:           if (start) state_next = st_load;
      // operands captured at the end of this cycle
      st_load:           state_next = st_exec;
      // datapaths settle, result registered at the end of this cycle
      st_exec:           state_next = st_done;
      st_done:           state_next = start ? st_wait_start_low : st_idle;
      st_wait_start_low: if (!start) state_next = st_idle;
      default:           state_next = st_idle;
    endcase
  end

  always_ff @(posedge clk, posedge arst) begin
    if (arst) begin
      state   <= st_idle;
      busy    <= 1'b0;
      cmd_end <= 1'b0;
    end else begin
      state   <= state_next;
      busy    <= state_next != st_idle;
      cmd_end <= (state_next == st_done) || (state_next == st_wait_start_low);
    end
  end

  assign load     = state == st_load;
  assign subtract = operation == op_sub;

  // result holds its value until the next command reaches st_exec
  always_ff @(posedge clk, posedge arst) begin
    if (arst) begin
      result <= '0;
    end else if (state == st_exec) begin
      case (operation)
        op_add, op_sub: result <= {sum.sign, sum.exp, sum.mant[`FPU_FRAC_W-1:0]};
        op_mul:         result <= {product.sign, product.exp, product.mant[`FPU_FRAC_W-1:0]};
        default:        result <= int_value;
      endcase
    end
  end

endmodule

//--- hw/fpu_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fpu top: add, sub, mul, float to int
// cmd_end rises 2 cycles after start is taken, held while start is high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "fpu_consts.svh"

module fpu_top (
  input  logic                  clk,
  input  logic                  arst,
  input  logic [`FPU_WIDTH-1:0] a_operand,
  input  logic [`FPU_WIDTH-1:0] b_operand,
  input  fpu_pkg::fpu_op_e      operation,
  input  logic                  start,
  output logic [`FPU_WIDTH-1:0] result,
  output logic                  busy,
  output logic                  cmd_end
);

  import fpu_pkg::*;

  fpu_unpacked_t         a;
  fpu_unpacked_t         b;
  fpu_unpacked_t         sum;
  fpu_unpacked_t         product;
  logic [`FPU_WIDTH-1:0] int_value;
  logic                  load;
  logic                  subtract;

  fpu_operand_regs u_regs (
    .clk       (clk),
    .arst      (arst),
    .a_operand (a_operand),
    .b_operand (b_operand),
    .load      (load),
    .a         (a),
    .b         (b)
  );

  fpu_addsub u_addsub (
    .a        (a),
    .b        (b),
    .subtract (subtract),
    .sum      (sum)
  );

  fpu_mul u_mul (
    .a       (a),
    .b       (b),
    .product (product)
  );

  // only operand a is converted
  fpu_float2int u_f2i (
    .a     (a),
    .value (int_value)
  );

  fpu_sequencer u_seq (
    .clk       (clk),
    .arst      (arst),
    .start     (start),
    .operation (operation),
    .sum       (sum),
    .product   (product),
    .int_value (int_value),
    .load      (load),
    .subtract  (subtract),
    .result    (result),
    .busy      (busy),
    .cmd_end   (cmd_end)
  );

endmodule

//--- run.sh
#!/bin/sh
# build and run the fpu testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sim.f --top-module fpu_tb -o fpu_sim
out=$(./obj_dir/fpu_sim)
echo "$out"

# a missing pass line ends the script with a failing status
echo "$out" | grep -q "ALL TESTS PASSED"

//--- sim.f
+incdir+hw
hw/fpu_pkg.sv
hw/fpu_operand_regs.sv
hw/fpu_addsub.sv
hw/fpu_mul.sv
hw/fpu_float2int.sv
hw/fpu_sequencer.sv
hw/fpu_top.sv
tb/fpu_checker.sv
tb/fpu_tb.sv

//--- tb/fpu_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// watches the fpu ports on the falling clock edge
// expected word and test name come from the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "fpu_consts.svh"

module fpu_checker (
  input  logic                  clk,
  input  logic                  arst,
  input  logic                  start,
  input  logic                  busy,
  input  logic                  cmd_end,
  input  logic [`FPU_WIDTH-1:0] result,
  input  logic [`FPU_WIDTH-1:0] exp_result,
  input  logic [8*16-1:0]       test_name,
  output int                    pass_count,
  output int                    fail_count
);

  // values seen at the previous falling edge
  logic                  p_start;
  logic                  p_busy;
  logic                  p_cmd_end;
  logic [`FPU_WIDTH-1:0] p_result;
  // set once the first command is taken
  logic                  started;
  int                    cycles;
  int                    test_errs;
  int                    reset_errs;

  task automatic finish_test(input logic [8*16-1:0] name, input int errs);
    if (errs == 0) begin
      $display("test %0s: ok", name);
      pass_count++;
    end else begin
      $display("test %0s: %0d errors", name, errs);
      fail_count++;
    end
  endtask

  task automatic check_value(input string edge_name);
    if (result !== exp_result) begin
      $display("ERR %0t: %0s at cmd_end %0s, result %h expected %h",
               $time, test_name, edge_name, result, exp_result);
      test_errs++;
    end
  endtask

  always @(negedge clk) begin
    if (arst) begin
      p_start    = 1'b0;
      p_busy     = 1'b0;
      p_cmd_end  = 1'b0;
      p_result   = '0;
      started    = 1'b0;
      cycles     = 0;
      test_errs  = 0;
      reset_errs = 0;
      pass_count = 0;
      fail_count = 0;
    end else begin
      if (!p_busy && p_start) begin
        // the edge just before this one took start
        if (!started) begin
          finish_test("reset", reset_errs);
          started = 1'b1;
        end
        cycles = 0;
        if (!busy || cmd_end) begin
          $display("%0s: busy did not rise at the edge that took start", test_name);
          test_errs++;
        end
      end else if (!p_busy && busy) begin
        $display("busy rose although start was low");
        test_errs++;
      end else if (busy) begin
        cycles++;
      end
      // idle outputs between reset and the first command
      if (!started && (busy !== 1'b0 || cmd_end !== 1'b0 || result !== '0)) begin
        $display("ERR %0t: outputs not idle after reset, busy %b cmd_end %b result %h",
                 $time, busy, cmd_end, result);
        reset_errs++;
      end
      if (p_busy && !p_cmd_end && !busy) begin
        $display("%0s: busy fell before cmd_end rose", test_name);
        test_errs++;
      end
      // start still high so everything must hold
      if (p_cmd_end && p_start) begin
        if (!cmd_end || !busy) begin
          $display("%0s: cmd_end or busy fell while start was held", test_name);
          test_errs++;
        end
        if (result !== p_result) begin
          $display("ERR %0t: %0s result moved from %h to %h while start was held",
                   $time, test_name, p_result, result);
          test_errs++;
        end
      end
      if (p_cmd_end && !p_start && (cmd_end || busy)) begin
        $display("%0s: busy and cmd_end did not fall at the edge that sampled start low",
                 test_name);
        test_errs++;
      end
      if (!p_cmd_end && cmd_end) begin
        if (cycles != 2) begin
          $display("%0s: cmd_end rose %0d cycles after the start edge, not 2",
                   test_name, cycles);
          test_errs++;
        end
        check_value("rise");
      end
      if (p_cmd_end && !cmd_end) begin
        check_value("fall");
        finish_test(test_name, test_errs);
        test_errs = 0;
      end
      p_start   = start;
      p_busy    = busy;
      p_cmd_end = cmd_end;
      p_result  = result;
    end
  end

endmodule

//--- tb/fpu_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed vectors, one command at a time
// expected words worked out by hand, normal operands only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "fpu_consts.svh"

module fpu_tb;

  import fpu_pkg::*;

  localparam int NUM_VECS   = 16;
  localparam int WAIT_LIMIT = 20;

  // one row of the table
  typedef struct packed {
    logic [8*16-1:0]       name;
    fpu_op_e               op;
    logic [`FPU_WIDTH-1:0] a;
    logic [`FPU_WIDTH-1:0] b;
    logic [`FPU_WIDTH-1:0] expv;
    logic [3:0]            extra;
  } test_vec_t;

  logic                  clk;
  logic                  arst;
  logic                  start;
  fpu_op_e               operation;
  logic [`FPU_WIDTH-1:0] a_operand;
  logic [`FPU_WIDTH-1:0] b_operand;
  logic [`FPU_WIDTH-1:0] result;
  logic                  busy;
  logic                  cmd_end;
  logic [8*16-1:0]       cur_name;
  logic [`FPU_WIDTH-1:0] cur_expect;
  int                    pass_count;
  int                    fail_count;
  logic                  timed_out;
  test_vec_t             vectors [NUM_VECS];

  fpu_top u_dut (
    .clk       (clk),
    .arst      (arst),
    .a_operand (a_operand),
    .b_operand (b_operand),
    .operation (operation),
    .start     (start),
    .result    (result),
    .busy      (busy),
    .cmd_end   (cmd_end)
  );

  fpu_checker u_chk (
    .clk        (clk),
    .arst       (arst),
    .start      (start),
    .busy       (busy),
    .cmd_end    (cmd_end),
    .result     (result),
    .exp_result (cur_expect),
    .test_name  (cur_name),
    .pass_count (pass_count),
    .fail_count (fail_count)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic test_vec_t make_vec(input logic [8*16-1:0] name, input fpu_op_e op,
                                         input logic [31:0] a, input logic [31:0] b,
                                         input logic [31:0] expv, input logic [3:0] extra);
    test_vec_t v;
    v.name  = name;
    v.op    = op;
    v.a     = a;
    v.b     = b;
    v.expv  = expv;
    v.extra = extra;
    return v;
  endfunction

  task automatic load_vectors();
    // add: carry out, alignment truncation, exact cancellation
    vectors[0]  = make_vec("add_carry", op_add, 32'h3FC00000, 32'h3FC00000, 32'h40400000, 4'd0);
    vectors[1]  = make_vec("add_align", op_add, 32'h3F800000, 32'h3E800001, 32'h3FA00000, 4'd0);
    vectors[2]  = make_vec("add_cancel", op_add, 32'h40400000, 32'hC0400000, 32'h00000000, 4'd0);
    // sub: 20 leading zeros, negative result, lost lsb
    vectors[3]  = make_vec("sub_lzc", op_sub, 32'h3F800008, 32'h3F800000, 32'h35800000, 4'd0);
    vectors[4]  = make_vec("sub_neg", op_sub, 32'h3F800000, 32'h40200000, 32'hBFC00000, 4'd0);
    vectors[5]  = make_vec("sub_trunc", op_sub, 32'h40000000, 32'h3F800001, 32'h3F800000, 4'd0);
    // 1.5 * 2.5, start held 5 more cycles
    vectors[6]  = make_vec("mul_exact", op_mul, 32'h3FC00000, 32'h40200000, 32'h40700000, 4'd5);
    vectors[7]  = make_vec("mul_top", op_mul, 32'hBFC00000, 32'h3FC00000, 32'hC0100000, 4'd0);
    // product 2^47 - 6*2^19, rounds up into a carry
    vectors[8]  = make_vec("mul_round", op_mul, 32'h3FC80000, 32'h3FA3D70A, 32'h40000000, 4'd0);
    vectors[9]  = make_vec("mul_tie_even", op_mul, 32'h3F800003, 32'h3FC00000, 32'h3FC00004, 4'd0);
    vectors[10] = make_vec("mul_tie_odd", op_mul, 32'h3F800001, 32'h3FC00000, 32'h3FC00002, 4'd0);
    vectors[11] = make_vec("mul_neg", op_mul, 32'hBFC00000, 32'h40200000, 32'hC0700000, 4'd0);
    // float to int, b unused
    vectors[12] = make_vec("f2i_small", op_float_to_int, 32'h3F400000, '0, 32'h00000000, 4'd0);
    vectors[13] = make_vec("f2i_14", op_float_to_int, 32'h41600000, '0, 32'h0000000E, 4'd2);
    vectors[14] = make_vec("f2i_exp30", op_float_to_int, 32'h4E800001, '0, 32'h40000080, 4'd0);
    vectors[15] = make_vec("f2i_neg", op_float_to_int, 32'hC1600000, '0, 32'h0000000E, 4'd0);
  endtask

  task automatic wait_cmd_end(input logic [8*16-1:0] name);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!cmd_end && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!cmd_end) begin
      $display("%0s: cmd_end did not rise within %0d cycles", name, WAIT_LIMIT);
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_idle(input logic [8*16-1:0] name);
    int waited;
    waited = 0;
    @(negedge clk);
    while (busy && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (busy) begin
      $display("%0s: busy did not fall within %0d cycles", name, WAIT_LIMIT);
      timed_out = 1'b1;
    end
  endtask

  task automatic run_vector(input test_vec_t v);
    @(posedge clk);
    operation  <= v.op;
    a_operand  <= v.a;
    b_operand  <= v.b;
    cur_name   <= v.name;
    cur_expect <= v.expv;
    start      <= 1'b1;
    wait_cmd_end(v.name);
    if (!timed_out) begin
      // result just waits while start stays high
      repeat (v.extra) @(posedge clk);
      @(posedge clk);
      start <= 1'b0;
      wait_idle(v.name);
    end
  endtask

  initial begin
    arst       = 1'b1;
    start      = 1'b0;
    operation  = op_add;
    a_operand  = '0;
    b_operand  = '0;
    cur_name   = "reset";
    cur_expect = '0;
    timed_out  = 1'b0;
    load_vectors();
    repeat (16) @(posedge clk);
    arst <= 1'b0;
    // a few idle cycles for the reset check
    repeat (3) @(posedge clk);
    for (int i = 0; i < NUM_VECS && !timed_out; i++) begin
      run_vector(vectors[i]);
    end
    repeat (2) @(posedge clk);
    $display("tests run %0d, ok %0d, failed %0d", pass_count + fail_count, pass_count,
             fail_count);
    if (!timed_out && fail_count == 0 && pass_count == NUM_VECS + 1) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
